// File: src/cache_cfg_pkg.sv
package cache_cfg_pkg;

  // core word
  localparam int XLEN = 64;

  // byte address split: tag | index | block offset
  localparam int ADDR_LEN = 32;
  localparam int TAG_LEN  = 20;
  localparam int IDX_LEN  = 6;
  localparam int BLK_LEN  = 6;

  localparam int SETS      = 1 << IDX_LEN;
  localparam int LINE_BITS = 128;                              // one bank word, quarter line
  localparam int BANKS     = ((1 << BLK_LEN) * 8) / LINE_BITS;
  localparam int BEATS     = ((1 << BLK_LEN) * 8) / XLEN;      // memory beats per line

  typedef logic [ADDR_LEN-1:0] addr_t;
  typedef logic [TAG_LEN-1:0]  tag_t;
  typedef logic [IDX_LEN-1:0]  idx_t;
  typedef logic [BLK_LEN-1:0]  blk_t;
  typedef logic [XLEN-1:0]     xlen_t;

  typedef logic [LINE_BITS-1:0]     bank_word_t;
  typedef logic [$clog2(BEATS)-1:0] beat_cnt_t;

endpackage

// File: src/cache_bus_pkg.sv
package cache_bus_pkg;

  import cache_cfg_pkg::*;

  localparam int STRB_LEN = XLEN / 8;

  typedef logic [STRB_LEN-1:0] strb_t;

  // core request, aligned 64-bit access
  typedef struct packed {
    addr_t addr;
    logic  write;
    xlen_t wdata;
    strb_t wstrb;
  } core_req_t;

  typedef struct packed {
    xlen_t rdata;
    logic  write;  // response belongs to a store
  } core_rsp_t;

  // line read, address is line aligned
  typedef struct packed {
    addr_t addr;
  } mem_rd_req_t;

  // single word write-through
  typedef struct packed {
    addr_t addr;
    xlen_t data;
    strb_t wstrb;
  } mem_wr_req_t;

endpackage

// File: src/sram_bank.sv
`timescale 1ns/100ps

module sram_bank #(
  parameter type word_t = logic [31:0],
  parameter int  DEPTH  = 64
) (
  input  logic                     clk,
  input  logic [$clog2(DEPTH)-1:0] addr_i,
  input  logic                     wen_i,    // active high
  input  word_t                    wmask_i,  // bit mask, 1 = write this bit
  input  word_t                    wdata_i,
  output word_t                    rdata_o
);

  word_t mem [DEPTH];

  // masked write, only selected bits change
  always_ff @(posedge clk) begin
    if (wen_i) begin
      mem[addr_i] <= (mem[addr_i] & ~wmask_i) | (wdata_i & wmask_i);
    end
  end

  // registered read, old word on a write cycle
  always_ff @(posedge clk) begin
    rdata_o <= mem[addr_i];
  end

endmodule

// File: src/dcache_tag.sv
`timescale 1ns/100ps

module dcache_tag
  import cache_cfg_pkg::*;
(
  input  logic clk,
  input  logic rst_n_i,
  input  idx_t idx_i,
  input  tag_t cmp_tag_i,  // compare cycle
  input  logic wen_i,
  input  tag_t wtag_i,
  output logic hit_o
);

  logic [SETS-1:0] valid_q;
  idx_t            idx_q;
  tag_t            rd_tag;

  // tag bits only, valid kept in flops
  sram_bank #(
    .word_t(tag_t),
    .DEPTH (SETS)
  ) u_tag_bank (
    .clk    (clk),
    .addr_i (idx_i),
    .wen_i  (wen_i),
    .wmask_i('1),
    .wdata_i(wtag_i),
    .rdata_o(rd_tag)
  );

  // writing a tag marks the line valid
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else if (wen_i) begin
      valid_q[idx_i] <= 1'b1;
    end
  end

  // index of the read in flight
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      idx_q <= '0;
    end else begin
      idx_q <= idx_i;
    end
  end

  assign hit_o = valid_q[idx_q] && (rd_tag == cmp_tag_i);

endmodule

// File: src/dcache_data.sv
`timescale 1ns/100ps

module dcache_data
  import cache_cfg_pkg::*;
(
  input  logic       clk,
  input  idx_t       index_i,
  input  blk_t       blk_addr_i,
  input  bank_word_t line_wdata_i,
  input  bank_word_t wmask_i,
  input  beat_cnt_t  burst_count_i,
  input  logic       allocate_valid_i,
  input  logic       wen_i,
  output xlen_t      rdata_o
);

  logic [1:0] wr_sel;
  logic [1:0] rd_sel;
  bank_word_t bank_q [BANKS];
  bank_word_t rd_word;

  // refill walks the banks by beat pair, hits go by offset
  always_comb begin
    if (allocate_valid_i) begin
      wr_sel = burst_count_i[2:1];
    end else begin
      wr_sel = blk_addr_i[5:4];
    end
  end

  // all banks share index, data and mask
  for (genvar b = 0; b < BANKS; b++) begin : g_bank
    logic bank_wen;

    assign bank_wen = wen_i && (wr_sel == 2'(b));  // only chosen bank writes

    sram_bank #(
      .word_t(bank_word_t),
      .DEPTH (SETS)
    ) u_data_bank (
      .clk    (clk),
      .addr_i (index_i),
      .wen_i  (bank_wen),
      .wmask_i(wmask_i),
      .wdata_i(line_wdata_i),
      .rdata_o(bank_q[b])
    );
  end

  // offset of the cycle the data comes back in
  assign rd_sel  = blk_addr_i[5:4];
  assign rd_word = bank_q[rd_sel];

  // 64 bits at byte offset within the bank word
  assign rdata_o = rd_word[{blk_addr_i[3:0], 3'b000} +: XLEN];

endmodule

// File: src/dcache_ctrl.sv
`timescale 1ns/100ps

module dcache_ctrl
  import cache_cfg_pkg::*;
  import cache_bus_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n_i,
  // core side
  input  core_req_t   core_req_i,
  input  logic        core_req_valid_i,
  output logic        core_ready_o,
  output core_rsp_t   core_rsp_o,
  output logic        core_rsp_valid_o,
  // memory side
  output mem_rd_req_t mem_rd_req_o,
  output logic        mem_rd_valid_o,
  input  logic        mem_beat_valid_i,
  input  xlen_t       mem_beat_data_i,
  output mem_wr_req_t mem_wr_req_o,
  output logic        mem_wr_valid_o,
  input  logic        mem_wr_done_i,
  // arrays
  input  logic        hit_i,
  input  xlen_t       rdata_i,
  output idx_t        arr_idx_o,
  output blk_t        arr_blk_o,
  output tag_t        cmp_tag_o,
  output bank_word_t  line_wdata_o,
  output bank_word_t  wmask_o,
  output beat_cnt_t   burst_count_o,
  output logic        allocate_o,
  output logic        data_wen_o,
  output logic        tag_wen_o,
  output tag_t        wtag_o
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_LOOKUP,
    S_REFILL,
    S_REPLAY,
    S_WR_WAIT
  } state_t;

  state_t    state_q;
  state_t    state_d;
  core_req_t req_q;
  beat_cnt_t beat_q;
  logic      wr_done_q;
  logic      last_beat;
  logic      rd_hit;
  logic      rd_miss;
  addr_t     arr_addr;
  xlen_t     strb_mask;

  assign core_ready_o = (state_q == S_IDLE);

  assign rd_hit    = (state_q == S_LOOKUP) && !req_q.write && hit_i;
  assign rd_miss   = (state_q == S_LOOKUP) && !req_q.write && !hit_i;
  assign last_beat = (state_q == S_REFILL) && mem_beat_valid_i &&
                     (beat_q == beat_cnt_t'(BEATS - 1));

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (core_req_valid_i) begin
          state_d = S_LOOKUP;
        end
      end
      S_LOOKUP: begin
        if (req_q.write) begin
          state_d = S_WR_WAIT;
        end else if (hit_i) begin
          state_d = S_IDLE;
        end else begin
          state_d = S_REFILL;
        end
      end
      S_REFILL: begin
        if (last_beat) begin
          state_d = S_REPLAY;
        end
      end
      S_REPLAY: state_d = S_LOOKUP;  // reread set, lookup then hits
      S_WR_WAIT: begin
        if (wr_done_q) begin
          state_d = S_IDLE;
        end
      end
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= S_IDLE;
      beat_q    <= '0;
      wr_done_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      wr_done_q <= mem_wr_done_i && (state_q == S_WR_WAIT);
      if (rd_miss) begin
        beat_q <= '0;
      end else if ((state_q == S_REFILL) && mem_beat_valid_i) begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

  // request held for the whole transaction
  always_ff @(posedge clk) begin
    if (core_ready_o && core_req_valid_i) begin
      req_q <= core_req_i;
    end
  end

  // array address comes straight from the core while idle
  assign arr_addr  = core_ready_o ? core_req_i.addr : req_q.addr;
  assign arr_idx_o = arr_addr[BLK_LEN +: IDX_LEN];
  assign arr_blk_o = arr_addr[BLK_LEN-1:0];
  assign cmp_tag_o = req_q.addr[ADDR_LEN-1 -: TAG_LEN];
  assign wtag_o    = cmp_tag_o;
  assign tag_wen_o = last_beat;  // tag lands with the eighth beat

  always_comb begin
    for (int i = 0; i < STRB_LEN; i++) begin
      strb_mask[i*8 +: 8] = {8{req_q.wstrb[i]}};
    end
  end

  // beat or store word goes to one half of the bank word
  always_comb begin
    if (state_q == S_REFILL) begin
      line_wdata_o = {mem_beat_data_i, mem_beat_data_i};
      wmask_o      = beat_q[0] ? {{XLEN{1'b1}}, {XLEN{1'b0}}} : {{XLEN{1'b0}}, {XLEN{1'b1}}};
    end else begin
      line_wdata_o = {req_q.wdata, req_q.wdata};
      wmask_o      = req_q.addr[3] ? {strb_mask, {XLEN{1'b0}}} : {{XLEN{1'b0}}, strb_mask};
    end
  end

  assign burst_count_o = beat_q;
  assign allocate_o    = (state_q == S_REFILL);
  assign data_wen_o    = ((state_q == S_REFILL) && mem_beat_valid_i) ||
                         ((state_q == S_LOOKUP) && req_q.write && hit_i);  // store hit

  assign core_rsp_valid_o = rd_hit || ((state_q == S_WR_WAIT) && wr_done_q);
  assign core_rsp_o.rdata = rdata_i;
  assign core_rsp_o.write = req_q.write;

  assign mem_rd_valid_o    = rd_miss;
  assign mem_rd_req_o.addr = {req_q.addr[ADDR_LEN-1:BLK_LEN], {BLK_LEN{1'b0}}};

  // every store goes out, hit or miss
  assign mem_wr_valid_o     = (state_q == S_LOOKUP) && req_q.write;
  assign mem_wr_req_o.addr  = req_q.addr;
  assign mem_wr_req_o.data  = req_q.wdata;
  assign mem_wr_req_o.wstrb = req_q.wstrb;

endmodule

// File: src/dcache_top.sv
`timescale 1ns/100ps

module dcache_top
  import cache_cfg_pkg::*;
  import cache_bus_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n_i,
  input  core_req_t   core_req_i,
  input  logic        core_req_valid_i,
  output logic        core_ready_o,
  output core_rsp_t   core_rsp_o,
  output logic        core_rsp_valid_o,
  output mem_rd_req_t mem_rd_req_o,
  output logic        mem_rd_valid_o,
  input  logic        mem_beat_valid_i,
  input  xlen_t       mem_beat_data_i,
  output mem_wr_req_t mem_wr_req_o,
  output logic        mem_wr_valid_o,
  input  logic        mem_wr_done_i
);

  logic       hit;
  xlen_t      rdata;
  idx_t       arr_idx;
  blk_t       arr_blk;
  tag_t       cmp_tag;
  bank_word_t line_wdata;
  bank_word_t wmask;
  beat_cnt_t  burst_count;
  logic       allocate;
  logic       data_wen;
  logic       tag_wen;
  tag_t       wtag;

  dcache_ctrl u_ctrl (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .core_req_i      (core_req_i),
    .core_req_valid_i(core_req_valid_i),
    .core_ready_o    (core_ready_o),
    .core_rsp_o      (core_rsp_o),
    .core_rsp_valid_o(core_rsp_valid_o),
    .mem_rd_req_o    (mem_rd_req_o),
    .mem_rd_valid_o  (mem_rd_valid_o),
    .mem_beat_valid_i(mem_beat_valid_i),
    .mem_beat_data_i (mem_beat_data_i),
    .mem_wr_req_o    (mem_wr_req_o),
    .mem_wr_valid_o  (mem_wr_valid_o),
    .mem_wr_done_i   (mem_wr_done_i),
    .hit_i           (hit),
    .rdata_i         (rdata),
    .arr_idx_o       (arr_idx),
    .arr_blk_o       (arr_blk),
    .cmp_tag_o       (cmp_tag),
    .line_wdata_o    (line_wdata),
    .wmask_o         (wmask),
    .burst_count_o   (burst_count),
    .allocate_o      (allocate),
    .data_wen_o      (data_wen),
    .tag_wen_o       (tag_wen),
    .wtag_o          (wtag)
  );

  dcache_tag u_tag (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .idx_i    (arr_idx),
    .cmp_tag_i(cmp_tag),
    .wen_i    (tag_wen),
    .wtag_i   (wtag),
    .hit_o    (hit)
  );

  dcache_data u_data (
    .clk             (clk),
    .index_i         (arr_idx),
    .blk_addr_i      (arr_blk),
    .line_wdata_i    (line_wdata),
    .wmask_i         (wmask),
    .burst_count_i   (burst_count),
    .allocate_valid_i(allocate),
    .wen_i           (data_wen),
    .rdata_o         (rdata)
  );

endmodule

// File: bench/dcache_mem_model.sv
`timescale 1ns/100ps

module dcache_mem_model
  import cache_cfg_pkg::*;
  import cache_bus_pkg::*;
(
  input  logic        clk,
  input  mem_rd_req_t rd_req_i,
  input  logic        rd_valid_i,
  output logic        beat_valid_o,
  output xlen_t       beat_data_o,
  input  mem_wr_req_t wr_req_i,
  input  logic        wr_valid_i,
  output logic        wr_done_o
);

  // write log, newest entry wins, unwritten words come from the fill pattern
  addr_t saved_addr [$];
  xlen_t saved_data [$];

  function automatic xlen_t fill_word(input addr_t a);
    return {a ^ 32'h5a3c96e1, (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]}};
  endfunction

  function automatic xlen_t read_word(input addr_t a);
    for (int i = saved_addr.size() - 1; i >= 0; i--) begin
      if (saved_addr[i] == a) begin
        return saved_data[i];
      end
    end
    return fill_word(a);
  endfunction

  initial begin
    xlen_t word;
    beat_valid_o = 1'b0;
    beat_data_o  = '0;
    wr_done_o    = 1'b0;
    forever begin
      @(negedge clk);
      if (rd_valid_i) begin
        for (int b = 0; b < BEATS; b++) begin
          @(negedge clk);  // first beat lands in the refill state
          beat_valid_o = 1'b0;
          repeat ($urandom_range(2, 0)) @(negedge clk);  // optional gap
          beat_valid_o = 1'b1;
          beat_data_o  = read_word(rd_req_i.addr + addr_t'(b * 8));
        end
        @(negedge clk);
        beat_valid_o = 1'b0;
      end else if (wr_valid_i) begin
        word = read_word(wr_req_i.addr);
        for (int i = 0; i < STRB_LEN; i++) begin
          if (wr_req_i.wstrb[i]) begin
            word[i*8 +: 8] = wr_req_i.data[i*8 +: 8];
          end
        end
        saved_addr.push_back(wr_req_i.addr);
        saved_data.push_back(word);
        repeat ($urandom_range(4, 1)) @(negedge clk);
        wr_done_o = 1'b1;
        @(negedge clk);
        wr_done_o = 1'b0;
      end
    end
  end

endmodule

// File: bench/dcache_tb.sv
`timescale 1ns/100ps

module dcache_tb
  import cache_cfg_pkg::*;
  import cache_bus_pkg::*;
();

  localparam int          NUM_REQS   = 2000;
  localparam int          CLK_PERIOD = 10;
  localparam int          TIMEOUT_NS = NUM_REQS * 200 * CLK_PERIOD;  // 200 cycles per request
  localparam int unsigned SEED       = 32'hece76a77;
  localparam int          TAGS       = 3;  // small pools force reuse and eviction
  localparam int          IDXS       = 4;

  logic        clk;
  logic        rst_n_i;
  core_req_t   core_req_i;
  logic        core_req_valid_i;
  logic        core_ready_o;
  core_rsp_t   core_rsp_o;
  logic        core_rsp_valid_o;
  mem_rd_req_t mem_rd_req_o;
  logic        mem_rd_valid_o;
  logic        mem_beat_valid_i;
  xlen_t       mem_beat_data_i;
  mem_wr_req_t mem_wr_req_o;
  logic        mem_wr_valid_o;
  logic        mem_wr_done_i;

  logic [7:0] shadow_mem [TAGS][IDXS][64];  // every byte the stimulus can reach
  tag_t       shadow_tag [SETS];
  logic       shadow_valid [SETS];
  int         n_hit = 0;
  int         n_miss = 0;
  int         n_evict = 0;
  int         n_st_hit = 0;

  dcache_top dcache_top_inst (.*);

  dcache_mem_model mem_model_inst (
    .clk         (clk),
    .rd_req_i    (mem_rd_req_o),
    .rd_valid_i  (mem_rd_valid_o),
    .beat_valid_o(mem_beat_valid_i),
    .beat_data_o (mem_beat_data_i),
    .wr_req_i    (mem_wr_req_o),
    .wr_valid_i  (mem_wr_valid_o),
    .wr_done_o   (mem_wr_done_i)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(TIMEOUT_NS);
    stop_on_error("timeout, the cache stopped answering requests");
  end

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(input string msg);
    stop_on_error($sformatf("Mismatch at %0t: %s", $time, msg));
  endtask

  function automatic tag_t tag_of(input int t);
    return tag_t'(t * 'h6b3d1 + 'h123);
  endfunction

  function automatic idx_t idx_of(input int j);
    return idx_t'(j * 21 + 3);
  endfunction

  // same pattern the memory model starts from
  function automatic xlen_t fill_word(input addr_t a);
    return {a ^ 32'h5a3c96e1, (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]}};
  endfunction

  function automatic xlen_t shadow_word(input int t, input int j, input int w);
    xlen_t word;
    for (int b = 0; b < STRB_LEN; b++) begin
      word[b*8 +: 8] = shadow_mem[t][j][w*8 + b];
    end
    return word;
  endfunction

  task automatic check_rsp(input core_rsp_t got, input core_rsp_t exp, input addr_t a);
    if (got.write !== exp.write) begin
      report_mismatch($sformatf("response write flag %b for access %h", got.write, a));
    end else if (!exp.write && got.rdata !== exp.rdata) begin  // store responses carry no data
      report_mismatch($sformatf("load %h returned %h, expected %h", a, got.rdata, exp.rdata));
    end
  endtask

  task automatic check_rd_req(input mem_rd_req_t got, input mem_rd_req_t exp);
    if (got !== exp) begin
      report_mismatch($sformatf("line read at %h, expected %h", got.addr, exp.addr));
    end
  endtask

  task automatic check_wr_req(input mem_wr_req_t got, input mem_wr_req_t exp);
    if (got !== exp) begin
      report_mismatch($sformatf("write-through %h %h %h, expected %h %h %h",
                                got.addr, got.data, got.wstrb, exp.addr, exp.data, exp.wstrb));
    end
  endtask

  task automatic do_request(input int t, input int j, input int w, input logic write);
    core_req_t   req;
    core_rsp_t   exp_rsp;
    mem_rd_req_t exp_rd;
    mem_wr_req_t exp_wr;
    idx_t        idx;
    logic        hit;
    logic        done;
    int          rd_seen;
    int          wr_seen;
    idx           = idx_of(j);
    hit           = shadow_valid[idx] && (shadow_tag[idx] == tag_of(t));
    req.addr      = {tag_of(t), idx, blk_t'(w * 8)};
    req.write     = write;
    req.wdata     = {$urandom, $urandom};
    req.wstrb     = strb_t'($urandom);
    exp_rsp.rdata = shadow_word(t, j, w);
    exp_rsp.write = write;
    exp_rd.addr   = {tag_of(t), idx, blk_t'(0)};
    exp_wr.addr   = req.addr;
    exp_wr.data   = req.wdata;
    exp_wr.wstrb  = req.wstrb;
    while (!core_ready_o) begin
      @(negedge clk);
    end
    core_req_i       = req;
    core_req_valid_i = 1'b1;
    @(negedge clk);
    core_req_valid_i = 1'b0;
    core_req_i       = core_req_t'({$urandom, $urandom, $urandom, $urandom});  // cache keeps a copy
    rd_seen = 0;
    wr_seen = 0;
    done    = 1'b0;
    while (!done) begin
      if (mem_rd_valid_o) begin
        rd_seen++;
        check_rd_req(mem_rd_req_o, exp_rd);
      end
      if (mem_wr_valid_o) begin
        wr_seen++;
        check_wr_req(mem_wr_req_o, exp_wr);
      end
      if (core_rsp_valid_o) begin
        check_rsp(core_rsp_o, exp_rsp, req.addr);
        done = 1'b1;
      end else begin
        @(negedge clk);
      end
    end
    if (rd_seen != ((write || hit) ? 0 : 1)) begin
      report_mismatch($sformatf("%0d line reads for %s %h",
                                rd_seen, write ? "store" : "load", req.addr));
    end
    if (wr_seen != (write ? 1 : 0)) begin
      report_mismatch($sformatf("%0d write-throughs for access %h", wr_seen, req.addr));
    end
    if (write) begin
      for (int b = 0; b < STRB_LEN; b++) begin
        if (req.wstrb[b]) begin
          shadow_mem[t][j][w*8 + b] = req.wdata[b*8 +: 8];
        end
      end
      n_st_hit += hit;  // store miss leaves the cache as it was
    end else if (hit) begin
      n_hit++;
    end else begin
      n_miss++;
      n_evict += shadow_valid[idx];  // another tag was resident
      shadow_valid[idx] = 1'b1;
      shadow_tag[idx]   = tag_of(t);
    end
  endtask

  initial begin
    int unsigned seed;
    xlen_t       word;
    seed = SEED;
    void'($urandom(seed));
    rst_n_i          = 1'b0;
    core_req_i       = '0;
    core_req_valid_i = 1'b0;
    for (int s = 0; s < SETS; s++) begin
      shadow_valid[s] = 1'b0;
    end
    for (int t = 0; t < TAGS; t++) begin
      for (int j = 0; j < IDXS; j++) begin
        for (int w = 0; w < BEATS; w++) begin
          word = fill_word({tag_of(t), idx_of(j), blk_t'(w * 8)});
          for (int b = 0; b < STRB_LEN; b++) begin
            shadow_mem[t][j][w*8 + b] = word[b*8 +: 8];
          end
        end
      end
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;
    if (!core_ready_o || core_rsp_valid_o || mem_rd_valid_o || mem_wr_valid_o) begin
      report_mismatch("after reset core_ready_o must be high and all valid pulses low");
    end
    for (int n = 0; n < NUM_REQS; n++) begin
      do_request($urandom_range(TAGS - 1, 0), $urandom_range(IDXS - 1, 0),
                 $urandom_range(BEATS - 1, 0), ($urandom_range(9, 0) < 4));
    end
    if (n_hit == 0 || n_miss == 0 || n_evict == 0 || n_st_hit == 0) begin
      stop_on_error("stimulus never produced a load hit, load miss, eviction and store hit");
    end else begin
      $display("%0d load hits, %0d load misses, %0d evictions, %0d store hits",
               n_hit, n_miss, n_evict, n_st_hit);
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

// File: project.f
src/cache_cfg_pkg.sv
src/cache_bus_pkg.sv
src/sram_bank.sv
src/dcache_tag.sv
src/dcache_data.sv
src/dcache_ctrl.sv
src/dcache_top.sv
bench/dcache_mem_model.sv
bench/dcache_tb.sv
